// File: compile.f
+incdir+verilog
verilog/lshape_data_pkg.sv
verilog/lshape_ctrl_pkg.sv
verilog/lshape_ifs.sv
verilog/flow_ctrl.sv
verilog/alu_pipe.sv
verilog/out_fifo.sv
verilog/lshape_top.sv
verif/lshape_props.sv
verif/lshape_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module lshape_tb

status=0
./obj_dir/Vlshape_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation run ok"
  exit 0
fi

echo "simulation run reported a problem"
exit 1

// File: verif/lshape_props.sv
`include "lshape_cfg.svh"

module lshape_props import lshape_ctrl_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    fifo_wr,
  input logic    fifo_full,
  input credit_t fifo_count,
  input credit_t credits,
  input logic    in_stall
);

  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    !(fifo_wr && fifo_full))
    else $error("fifo written while full");

  a_count_in_range: assert property (@(posedge clk) disable iff (rst)
    fifo_count <= credit_t'(`LSHAPE_FIFO_DEPTH))
    else $error("fifo occupancy above depth");

  // items still in the pipeline hold a credit but no slot yet
  a_credit_sum: assert property (@(posedge clk) disable iff (rst)
    (int'(credits) + int'(fifo_count)) <= `LSHAPE_FIFO_DEPTH)
    else $error("credits plus occupancy above depth");

  a_stall_iff_empty_credits: assert property (@(posedge clk) disable iff (rst)
    in_stall == (credits == '0))
    else $error("in_stall does not follow the credit count");

endmodule

bind lshape_top lshape_props u_props (
  .clk        (clk),
  .rst        (rst),
  .fifo_wr    (res.wr),
  .fifo_full  (u_fifo.full),
  .fifo_count (u_fifo.count),
  .credits    (u_ctrl.credits),
  .in_stall   (in_stall)
);

// File: verif/lshape_tb.sv
`include "lshape_cfg.svh"

module lshape_tb import lshape_data_pkg::*, lshape_ctrl_pkg::*; ();

  localparam int N_ITEMS = 400;
  localparam int LIMIT   = N_ITEMS * (`LSHAPE_LAT + 8);

  typedef struct packed {
    operand_t    result;
    logic        zero;
    logic        neg;
    tag_t        tag;
    logic [31:0] edge_n; // rising edge that accepted the item
  } expect_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  op_t         in_op;
  operand_t    in_a;
  operand_t    in_b;
  tag_t        in_tag;
  logic        in_stall;
  logic        out_rdreq;
  logic        out_empty;
  operand_t    out_result;
  logic        out_zero;
  logic        out_neg;
  tag_t        out_tag;

  expect_t     model_q [$];
  int          credits_m;
  int          errors = 0;
  int          sent   = 0;
  int unsigned edges  = 0;

  lshape_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_tag     (in_tag),
    .in_stall   (in_stall),
    .out_rdreq  (out_rdreq),
    .out_empty  (out_empty),
    .out_result (out_result),
    .out_zero   (out_zero),
    .out_neg    (out_neg),
    .out_tag    (out_tag)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    edges <= edges + 1;
    if (edges >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic compare_data(string name, operand_t got, operand_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_tag(string name, tag_t got, tag_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  // expected result straight from the add/subtract rule
  task automatic push_item();
    expect_t e;
    e.result = in_op ? in_a + in_b : in_a - in_b;
    e.zero   = (e.result == '0);
    e.neg    = e.result[`LSHAPE_DATA_W-1];
    e.tag    = in_tag;
    e.edge_n = edges + 1;
    model_q.push_back(e);
  endtask

  // one cycle: drive on the falling edge, check, then update the model
  task automatic step(int unsigned valid_pct, int unsigned rd_pct);
    logic    acc;
    logic    pp;
    logic    exp_empty;
    expect_t head;
    @(negedge clk);
    in_valid  = ($urandom % 100) < valid_pct;
    in_op     = op_t'($urandom % 2);
    in_a      = operand_t'($urandom);
    in_b      = ($urandom % 8 == 0) ? in_a : operand_t'($urandom); // some zero results
    in_tag    = tag_t'($urandom);
    out_rdreq = ($urandom % 100) < rd_pct;
    #1;
    compare_flag("in_stall", in_stall, credits_m == 0);
    if (model_q.size() == 0) begin
      exp_empty = 1'b1;
    end else begin
      exp_empty = (model_q[0].edge_n + `LSHAPE_LAT > edges); // head not landed yet
    end
    compare_flag("out_empty", out_empty, exp_empty);
    acc = in_valid & ~in_stall;
    pp  = out_rdreq & ~out_empty;
    if (pp) begin
      if (model_q.size() == 0) begin
        errors++;
        $display("fifo offered a result that was never sent");
      end else begin
        head = model_q.pop_front();
        compare_data("out_result", out_result, head.result);
        compare_flag("out_zero", out_zero, head.zero);
        compare_flag("out_neg", out_neg, head.neg);
        compare_tag("out_tag", out_tag, head.tag);
      end
    end
    if (acc) begin
      push_item();
      sent++;
    end
    if (acc && !pp) credits_m--;
    if (pp && !acc) credits_m++;
  endtask

  task automatic drain();
    while (model_q.size() != 0) begin
      step(0, 100);
    end
    repeat (2) step(0, 0);
  endtask

  initial begin
    int start;
    void'($urandom(37925));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_op     = 1'b0;
    in_a      = '0;
    in_b      = '0;
    in_tag    = '0;
    out_rdreq = 1'b0;
    credits_m = `LSHAPE_FIFO_DEPTH;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    compare_flag("in_stall", in_stall, 1'b0);
    compare_flag("out_empty", out_empty, 1'b1);

    // reads held off, only the credits may get in
    start = sent;
    repeat (`LSHAPE_FIFO_DEPTH + `LSHAPE_LAT + 4) step(100, 0);
    if (sent - start != `LSHAPE_FIFO_DEPTH) begin
      errors++;
      $display("with no reads %0d items were accepted instead of %0d",
               sent - start, `LSHAPE_FIFO_DEPTH);
    end
    drain();

    while (sent < N_ITEMS) begin
      case ((edges / 100) % 4)
        0: step(70, 70);
        1: step(70, 2);   // downstream nearly idle
        2: step(2, 70);   // upstream nearly idle
        default: step(70, 70);
      endcase
    end
    drain();

    $display("errors: %0d, items sent: %0d", errors, sent);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/alu_pipe.sv
`include "lshape_cfg.svh"

module alu_pipe import lshape_data_pkg::*; #(
  parameter int LAT = `LSHAPE_LAT
) (
  input  logic clk,
  input  logic rst,
  issue_if.dst iss,
  result_if.src res
);

  logic [LAT-1:0] vld;         // bit i set when stage i holds an item
  operand_t       stage_res [LAT];
  tag_t           stage_tag [LAT];
  operand_t       alu_out;
  operand_t       last_res;

  // wraps modulo 2^W, no carry or borrow kept
  always_comb begin
    if (iss.op == OP_ADD) begin
      alu_out = iss.a + iss.b;
    end else begin
      alu_out = iss.a - iss.b;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      vld <= '0;
      for (int i = 0; i < LAT; i++) begin
        stage_res[i] <= '0;
        stage_tag[i] <= '0;
      end
    end else begin
      vld          <= {vld[LAT-2:0], iss.valid};
      stage_res[0] <= alu_out;
      stage_tag[0] <= iss.tag;
      for (int i = 1; i < LAT; i++) begin
        stage_res[i] <= stage_res[i-1];
        stage_tag[i] <= stage_tag[i-1];
      end
    end
  end

  assign last_res = stage_res[LAT-1];

  // flags come from the last stage only
  assign res.wr     = vld[LAT-1];
  assign res.result = last_res;
  assign res.zero   = (last_res == '0);
  assign res.neg    = last_res[`LSHAPE_DATA_W-1];
  assign res.tag    = stage_tag[LAT-1];

endmodule

// File: verilog/flow_ctrl.sv
`include "lshape_cfg.svh"

module flow_ctrl import lshape_data_pkg::*, lshape_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  op_t      in_op,
  input  operand_t in_a,
  input  operand_t in_b,
  input  tag_t     in_tag,
  output logic     in_stall,
  input  logic     pop,
  issue_if.src     iss
);

  credit_t       credits;
  credit_t       credits_next;
  credit_state_e state;
  credit_state_e state_next;
  logic          accept;

  // every accepted item already owns a fifo slot
  assign in_stall = (state == CR_EXHAUSTED);
  assign accept   = in_valid & ~in_stall;

  // issue in the accept cycle, no register in between
  assign iss.valid = accept;
  assign iss.op    = in_op;
  assign iss.a     = in_a;
  assign iss.b     = in_b;
  assign iss.tag   = in_tag;

  always_comb begin
    case ({accept, pop})
      2'b10:   credits_next = credits - 1'b1; // spend one slot
      2'b01:   credits_next = credits + 1'b1; // slot freed by a read
      default: credits_next = credits;        // none, or both at once
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      CR_OPEN: begin
        if (credits_next == '0) state_next = CR_EXHAUSTED;
      end
      CR_EXHAUSTED: begin
        if (credits_next != '0) state_next = CR_OPEN;
      end
      default: state_next = CR_OPEN;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      credits <= credit_t'(`LSHAPE_FIFO_DEPTH); // fifo starts empty
      state   <= CR_OPEN;
    end else begin
      credits <= credits_next;
      state   <= state_next;
    end
  end

endmodule

// File: verilog/lshape_cfg.svh
`ifndef LSHAPE_CFG_SVH
`define LSHAPE_CFG_SVH

// operand and result width
`define LSHAPE_DATA_W 16

// tag that follows each item from issue to the fifo head
`define LSHAPE_TAG_W 4

`define LSHAPE_LAT 5 // issue to fifo write, at least 2

`define LSHAPE_FIFO_DEPTH 8 // power of two

`endif

// File: verilog/lshape_ctrl_pkg.sv
`include "lshape_cfg.svh"

package lshape_ctrl_pkg;

  // free fifo slots, 0 up to the depth; doubles as fifo occupancy
  typedef logic [$clog2(`LSHAPE_FIFO_DEPTH):0] credit_t;

  typedef enum logic {
    CR_OPEN,      // at least one credit left
    CR_EXHAUSTED  // upstream is stalled
  } credit_state_e;

endpackage

// File: verilog/lshape_data_pkg.sv
`include "lshape_cfg.svh"

package lshape_data_pkg;

  // one operand, also one result
  typedef logic [`LSHAPE_DATA_W-1:0] operand_t;

  typedef logic [`LSHAPE_TAG_W-1:0] tag_t;

  // 1 selects a + b, 0 selects a - b
  typedef logic op_t;

  localparam op_t OP_ADD = 1'b1;

endpackage

// File: verilog/lshape_ifs.sv
// one accepted item going from flow control into the pipeline
interface issue_if import lshape_data_pkg::*; ();

  logic     valid; // one cycle per accepted item, never refused
  op_t      op;
  operand_t a;
  operand_t b;
  tag_t     tag;

  modport src (
    output valid, op, a, b, tag
  );

  modport dst (
    input valid, op, a, b, tag
  );

endinterface

// one finished result going from the pipeline into the fifo
interface result_if import lshape_data_pkg::*; ();

  logic     wr; // writes one entry at the next edge
  operand_t result;
  logic     zero;
  logic     neg;
  tag_t     tag;

  modport src (
    output wr, result, zero, neg, tag
  );

  modport dst (
    input wr, result, zero, neg, tag
  );

endinterface

// File: verilog/lshape_top.sv
`include "lshape_cfg.svh"

module lshape_top import lshape_data_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  // upstream side
  input  logic     in_valid,
  input  op_t      in_op,
  input  operand_t in_a,
  input  operand_t in_b,
  input  tag_t     in_tag,
  output logic     in_stall,
  // downstream side
  input  logic     out_rdreq,
  output logic     out_empty,
  output operand_t out_result,
  output logic     out_zero,
  output logic     out_neg,
  output tag_t     out_tag
);

  logic fifo_pop; // one credit back per read

  issue_if  iss ();
  result_if res ();

  flow_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_tag   (in_tag),
    .in_stall (in_stall),
    .pop      (fifo_pop),
    .iss      (iss.src)
  );

  alu_pipe #(
    .LAT (`LSHAPE_LAT)
  ) u_alu (
    .clk (clk),
    .rst (rst),
    .iss (iss.dst),
    .res (res.src)
  );

  out_fifo #(
    .DEPTH (`LSHAPE_FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .rst         (rst),
    .wr_port     (res.dst),
    .rdreq       (out_rdreq),
    .empty       (out_empty),
    .pop         (fifo_pop),
    .head_result (out_result),
    .head_zero   (out_zero),
    .head_neg    (out_neg),
    .head_tag    (out_tag)
  );

endmodule

// File: verilog/out_fifo.sv
`include "lshape_cfg.svh"

module out_fifo import lshape_data_pkg::*, lshape_ctrl_pkg::*; #(
  parameter int DEPTH = `LSHAPE_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  result_if.dst    wr_port,
  input  logic     rdreq,
  output logic     empty,
  output logic     pop,
  output operand_t head_result,
  output logic     head_zero,
  output logic     head_neg,
  output tag_t     head_tag
);

  localparam int AW = $clog2(DEPTH);

  operand_t       mem_result [DEPTH];
  tag_t           mem_tag    [DEPTH];
  logic [DEPTH-1:0] mem_zero;
  logic [DEPTH-1:0] mem_neg;

  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;
  credit_t       count;      // occupancy
  credit_t       count_next;
  logic          full;

  assign empty = (count == '0);
  assign full  = (count == credit_t'(DEPTH)); // credits keep writes away from this
  assign pop   = rdreq & ~empty;

  // head entry straight out of the array
  assign head_result = mem_result[rd_ptr];
  assign head_zero   = mem_zero[rd_ptr];
  assign head_neg    = mem_neg[rd_ptr];
  assign head_tag    = mem_tag[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_port.wr) begin
      mem_result[wr_ptr] <= wr_port.result;
      mem_zero[wr_ptr]   <= wr_port.zero;
      mem_neg[wr_ptr]    <= wr_port.neg;
      mem_tag[wr_ptr]    <= wr_port.tag;
    end
  end

  always_comb begin
    case ({wr_port.wr, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_port.wr) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count_next;
    end
  end

endmodule
